/* design/dvi_out.sv */
`timescale 1ns/1ps

module dvi_out import scanout_pkg::*; (
	input  logic      clk_25mhz,
	input  logic      rst_n,
	input  vsync_t    sync_in,
	input  pixel_t    rd_data,
	output pixel_t    pixel,
	output vsync_t    sync,
	output dvi_word_t dvi
);

	// First delay stage, lines up with rd_data
	vsync_t      sync_d1;
	pixel_t      pix_n;
	logic [23:0] gbrg;

	// Nothing visible outside active video
	assign pix_n = sync_d1.blank ? '0 : rd_data;

	// Green low nibble, blue, red, green high nibble
	assign gbrg = {pix_n.g[3:0], pix_n.b, pix_n.r, pix_n.g[7:4]};

	always_ff @(posedge clk_25mhz or negedge rst_n) begin
		if (!rst_n) begin
			sync_d1 <= SYNC_IDLE;
			sync    <= SYNC_IDLE;
			pixel   <= '0;
			dvi     <= '0;
		end else begin
			sync_d1 <= sync_in;
			sync    <= sync_d1;
			pixel   <= pix_n;
			// Both halves, the pad DDR cell picks one per edge
			dvi.hi  <= gbrg[23:12];
			dvi.lo  <= gbrg[11:0];
		end
	end

endmodule

/* design/frame_fetch.sv */
`timescale 1ns/1ps

module frame_fetch import scanout_pkg::*; (
	input  logic                  clk_25mhz,
	input  logic                  rst_n,
	input  logic                  fetch_restart,
	input  logic [ADDR_W-1:0]     fetch_base,
	input  logic [FIFO_LVL_W-1:0] level,
	output wb_req_t               wb_req,
	input  wb_rsp_t               wb_rsp,
	output logic                  wr_en,
	output pixel_t                wr_data
);

	logic              cyc_q;
	logic [ADDR_W-1:0] adr_q;
	logic [ADDR_W-1:0] offset;
	// Pending read belongs to an abandoned frame
	logic              drop;

	logic              ack_take;
	logic              bus_free;
	logic              issue;
	logic [ADDR_W-1:0] off_n;
	logic              drop_n;

	assign ack_take = cyc_q && wb_rsp.ack;
	// No transfer open, or the open one finishes now
	assign bus_free = !cyc_q || ack_take;

	////////////////////
	// Next offset
	////////////////////

	always_comb begin
		off_n  = offset;
		drop_n = drop;
		if (fetch_restart) begin
			off_n  = '0;
			// Let an open read finish, then throw its data away
			drop_n = cyc_q && !wb_rsp.ack;
		end else if (ack_take) begin
			if (!drop)
				off_n = offset + 1'b1;
			drop_n = 1'b0;
		end
	end

	// Frame not done and at least two free entries
	assign issue = (off_n < ADDR_W'(FRAME_WORDS)) &&
	               (level <= FIFO_LVL_W'(FIFO_DEPTH - 2));

	always_ff @(posedge clk_25mhz or negedge rst_n) begin
		if (!rst_n) begin
			cyc_q  <= 1'b0;
			adr_q  <= '0;
			offset <= '0;
			drop   <= 1'b0;
		end else begin
			offset <= off_n;
			drop   <= drop_n;
			if (bus_free) begin
				cyc_q <= issue;
				// Base plus offset, held until ack
				if (issue)
					adr_q <= fetch_base + off_n;
			end
		end
	end

	assign wb_req.cyc = cyc_q;
	assign wb_req.stb = cyc_q;
	assign wb_req.adr = adr_q;

	// Low 24 bits of the acked word, r in the top byte
	assign wr_en   = ack_take && !drop;
	assign wr_data = pixel_t'(wb_rsp.dat[23:0]);

endmodule

/* design/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo import scanout_pkg::*; (
	input  logic                  clk_25mhz,
	input  logic                  rst_n,
	input  logic                  flush,
	input  logic                  wr_en,
	input  pixel_t                wr_data,
	input  logic                  rd_req,
	output pixel_t                rd_data,
	output logic                  empty,
	output logic [FIFO_LVL_W-1:0] level
);

	pixel_t mem [FIFO_DEPTH];

	// Extra top bit tells full from empty
	logic [FIFO_LVL_W-1:0] wr_ptr;
	logic [FIFO_LVL_W-1:0] rd_ptr;
	logic                  full;
	logic                  do_wr;
	logic                  do_rd;

	assign level = wr_ptr - rd_ptr;
	assign empty = (level == '0);
	assign full  = (level == FIFO_LVL_W'(FIFO_DEPTH));

	// Flush wins over a write in the same cycle
	assign do_wr = wr_en && !full && !flush;
	assign do_rd = rd_req && !empty;

	always_ff @(posedge clk_25mhz or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_25mhz) begin
		if (do_wr)
			mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
	end

	// Read port, black on underrun
	always_ff @(posedge clk_25mhz) begin
		if (rd_req)
			rd_data <= do_rd ? mem[rd_ptr[FIFO_AW-1:0]] : '0;
	end

endmodule

/* design/scanout_ctrl.sv */
`timescale 1ns/1ps

module scanout_ctrl import scanout_pkg::*; (
	input  logic                  clk_25mhz,
	input  logic                  rst_n,
	input  logic                  display_on,
	input  logic [ADDR_W-1:0]     mem_start,
	input  logic [FIFO_LVL_W-1:0] level,
	input  logic                  frame_end,
	input  logic                  rd_req,
	input  logic                  empty,
	output logic                  timing_run,
	output logic                  fetch_restart,
	output logic [ADDR_W-1:0]     fetch_base,
	output logic                  fifo_flush,
	output logic                  underrun,
	output logic                  dvi_rst_n
);

	// OFF while the display is disabled
	// PRIME fills the FIFO before the first frame
	// RUN streams frames back to back
	typedef enum logic [1:0] {
		OFF,
		PRIME,
		RUN
	} state_t;

	state_t state;

	////////////////////
	// Sequencing
	////////////////////

	always_ff @(posedge clk_25mhz or negedge rst_n) begin
		if (!rst_n) begin
			state         <= OFF;
			fetch_restart <= 1'b0;
			fifo_flush    <= 1'b0;
			fetch_base    <= '0;
			underrun      <= 1'b0;
		end else begin
			// Single cycle pulses by default
			fetch_restart <= 1'b0;
			fifo_flush    <= 1'b0;
			if (!display_on) begin
				// Display off drops everything, sticky flag too
				state    <= OFF;
				underrun <= 1'b0;
			end else begin
				case (state)
					OFF: begin
						// Enable seen, start the first fill
						state         <= PRIME;
						fetch_base    <= mem_start;
						fetch_restart <= 1'b1;
						fifo_flush    <= 1'b1;
					end
					PRIME: begin
						// Wait time depends on memory wait states
						if (level >= FIFO_LVL_W'(PRIME_LEVEL))
							state <= RUN;
					end
					RUN: begin
						// Frame boundary, base for next frame
						if (frame_end) begin
							fetch_base    <= mem_start;
							fetch_restart <= 1'b1;
							fifo_flush    <= 1'b1;
						end
						// Display can't stall, so only flag it
						if (rd_req && empty)
							underrun <= 1'b1;
					end
					default: state <= OFF;
				endcase
			end
		end
	end

	// Counters and DVI chip come alive together
	assign timing_run = (state == RUN);
	assign dvi_rst_n  = (state == RUN);

endmodule

/* design/scanout_pkg.sv */
package scanout_pkg;

	////////////////////
	// Video timing, 640x480 at 60 Hz
	////////////////////

	// Horizontal, in pixel clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Counter width, covers 800 and 525
	localparam int CNT_W = 10;

	// One memory word per visible pixel
	localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;

	////////////////////
	// Memory and FIFO sizing
	////////////////////

	// Wishbone word address width
	localparam int ADDR_W = 28;

	localparam int FIFO_DEPTH  = 64;
	localparam int FIFO_AW     = 6;
	// One extra bit so full and empty differ
	localparam int FIFO_LVL_W  = FIFO_AW + 1;
	// Fill level needed before the first line goes out
	localparam int PRIME_LEVEL = 48;

	////////////////////
	// Shared bundles
	////////////////////

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

	// Syncs active low, blank active high
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank;
	} vsync_t;

	// Idle video control levels
	localparam vsync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1};

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic [ADDR_W-1:0] adr;
	} wb_req_t;

	typedef struct packed {
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

	typedef struct packed {
		logic [11:0] hi;
		logic [11:0] lo;
	} dvi_word_t;

endpackage

/* design/scanout_top.sv */
`timescale 1ns/1ps

module scanout_top import scanout_pkg::*; (
	input  logic              clk_25mhz,
	input  logic              rst_n,
	input  logic              display_on,
	input  logic [ADDR_W-1:0] mem_start,
	output wb_req_t           wb_req,
	input  wb_rsp_t           wb_rsp,
	output pixel_t            pixel,
	output vsync_t            sync,
	output dvi_word_t         dvi,
	output logic              dvi_rst_n,
	output logic              underrun
);

	// Datapath held in reset while the display is off
	logic                  core_rst_n;

	logic                  timing_run;
	logic                  fetch_restart;
	logic [ADDR_W-1:0]     fetch_base;
	logic                  fifo_flush;
	logic [FIFO_LVL_W-1:0] level;
	logic                  frame_end;
	logic                  rd_req;
	logic                  empty;
	logic                  wr_en;
	pixel_t                wr_data;
	pixel_t                rd_data;
	vsync_t                timing_sync;

	assign core_rst_n = rst_n & display_on;

	scanout_ctrl u_ctrl (
		.clk_25mhz(clk_25mhz), .rst_n(rst_n), .display_on(display_on),
		.mem_start(mem_start), .level(level), .frame_end(frame_end),
		.rd_req(rd_req), .empty(empty), .timing_run(timing_run),
		.fetch_restart(fetch_restart), .fetch_base(fetch_base),
		.fifo_flush(fifo_flush), .underrun(underrun), .dvi_rst_n(dvi_rst_n)
	);

	vga_timing u_timing (
		.clk_25mhz(clk_25mhz), .rst_n(core_rst_n), .timing_run(timing_run),
		.sync(timing_sync), .rd_req(rd_req), .frame_end(frame_end)
	);

	frame_fetch u_fetch (
		.clk_25mhz(clk_25mhz), .rst_n(core_rst_n), .fetch_restart(fetch_restart),
		.fetch_base(fetch_base), .level(level), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.wr_en(wr_en), .wr_data(wr_data)
	);

	pixel_fifo u_fifo (
		.clk_25mhz(clk_25mhz), .rst_n(core_rst_n), .flush(fifo_flush),
		.wr_en(wr_en), .wr_data(wr_data), .rd_req(rd_req), .rd_data(rd_data),
		.empty(empty), .level(level)
	);

	dvi_out u_dvi (
		.clk_25mhz(clk_25mhz), .rst_n(core_rst_n), .sync_in(timing_sync),
		.rd_data(rd_data), .pixel(pixel), .sync(sync), .dvi(dvi)
	);

endmodule

/* design/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import scanout_pkg::*; (
	input  logic   clk_25mhz,
	input  logic   rst_n,
	input  logic   timing_run,
	output vsync_t sync,
	output logic   rd_req,
	output logic   frame_end
);

	logic [CNT_W-1:0] h_cnt;
	logic [CNT_W-1:0] v_cnt;
	logic             h_last;
	logic             v_last;
	logic             active;

	assign h_last = (h_cnt == CNT_W'(H_TOTAL - 1));
	assign v_last = (v_cnt == CNT_W'(V_TOTAL - 1));

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clk_25mhz or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (!timing_run) begin
			// Parked at the top left corner
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				// Next line, wrap at frame end
				if (v_last)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Decode
	////////////////////

	assign active = (h_cnt < CNT_W'(H_ACTIVE)) && (v_cnt < CNT_W'(V_ACTIVE));

	always_comb begin
		sync = SYNC_IDLE;
		if (timing_run) begin
			// Sync pulse after front porch
			sync.hsync = !((h_cnt >= CNT_W'(H_ACTIVE + H_FRONT)) &&
			               (h_cnt <  CNT_W'(H_ACTIVE + H_FRONT + H_SYNC)));
			sync.vsync = !((v_cnt >= CNT_W'(V_ACTIVE + V_FRONT)) &&
			               (v_cnt <  CNT_W'(V_ACTIVE + V_FRONT + V_SYNC)));
			sync.blank = !active;
		end
	end

	// One FIFO pop per visible pixel
	assign rd_req = timing_run && active;

	// Last visible pixel of the frame; the whole vertical blank
	// after it is left for the refill
	assign frame_end = timing_run &&
	                   (h_cnt == CNT_W'(H_ACTIVE - 1)) &&
	                   (v_cnt == CNT_W'(V_ACTIVE - 1));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the scanout testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_scanout -f scanout.f -o tb_scanout
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_scanout > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* scanout.f */
design/scanout_pkg.sv
design/scanout_ctrl.sv
design/vga_timing.sv
design/frame_fetch.sv
design/pixel_fifo.sv
design/dvi_out.sv
design/scanout_top.sv
sim/scanout_assertions.sv
sim/tb_scanout.sv

/* sim/scanout_assertions.sv */
`timescale 1ns/1ps

module scanout_assertions import scanout_pkg::*; (
	input logic              clk,
	input logic              rst_n,
	input logic              cyc,
	input logic              stb,
	input logic [ADDR_W-1:0] adr,
	input logic              ack,
	input logic              wr_en,
	input logic              full
);

	// Strobe only inside a bus cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		stb |-> cyc)
		else $error("Wishbone stb high without cyc");

	// Request and address held until the slave acks
	adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(stb && !ack) |=> (stb && $stable(adr)))
		else $error("Wishbone request changed while waiting for ack");

	// Fetch must leave headroom in the FIFO
	no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !full)
		else $error("write into a full pixel FIFO");

endmodule

// Bus side, FIFO inputs tied off
bind frame_fetch scanout_assertions u_bus_checks (
	.clk(clk_25mhz), .rst_n(rst_n), .cyc(wb_req.cyc), .stb(wb_req.stb),
	.adr(wb_req.adr), .ack(wb_rsp.ack), .wr_en(1'b0), .full(1'b0)
);

// FIFO side, bus inputs tied off
bind pixel_fifo scanout_assertions u_fifo_checks (
	.clk(clk_25mhz), .rst_n(rst_n), .cyc(1'b0), .stb(1'b0), .adr('0),
	.ack(1'b0), .wr_en(wr_en), .full(full)
);

/* sim/tb_scanout.sv */
`timescale 1ns/1ps

module tb_scanout import scanout_pkg::*; ();

	logic              clk_25mhz;
	logic              rst_n;
	logic              display_on;
	logic [ADDR_W-1:0] mem_start;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	pixel_t            pixel;
	vsync_t            sync;
	dvi_word_t         dvi;
	logic              dvi_rst_n;
	logic              underrun;

	// Memory model and compare controls
	logic              ack_hold;
	logic              compare_en;
	logic [ADDR_W-1:0] frame_base;
	int                frames_done;
	int                cmp_x;
	int                cmp_y;

	// Bookkeeping
	int                checks;
	int                errors;
	int                dvi_errors;
	int                tests_run;
	int                tests_failed;
	logic              hung;

	scanout_top UUT (
		.clk_25mhz(clk_25mhz), .rst_n(rst_n), .display_on(display_on),
		.mem_start(mem_start), .wb_req(wb_req), .wb_rsp(wb_rsp), .pixel(pixel),
		.sync(sync), .dvi(dvi), .dvi_rst_n(dvi_rst_n), .underrun(underrun)
	);

	always #10 clk_25mhz = ~clk_25mhz;

	////////////////////
	// Memory model
	////////////////////

	// Every address bit reaches the low 24 bits
	function automatic logic [31:0] mem_word(logic [ADDR_W-1:0] a);
		logic [31:0] w;
		w = 32'(a) * 32'h2545f491;
		return w ^ {a[11:0], a[27:8]};
	endfunction

	// Zero wait states unless the hold is on
	assign wb_rsp = '{dat: mem_word(wb_req.adr), ack: wb_req.cyc && wb_req.stb && !ack_hold};

	////////////////////
	// Reference model
	////////////////////

	// Row major order with 640 words per line
	function automatic pixel_t expected_pixel(logic [ADDR_W-1:0] base, int x, int y);
		logic [ADDR_W-1:0] a;
		logic [31:0]       w;
		a = base + ADDR_W'(y * 640 + x);
		w = mem_word(a);
		return pixel_t'(w[23:0]);
	endfunction

	// Green low nibble, blue, red, green high nibble
	function automatic dvi_word_t dvi_pack(pixel_t p);
		dvi_word_t d;
		d.hi = {p.g[3:0], p.b};
		d.lo = {p.r, p.g[7:4]};
		return d;
	endfunction

	function automatic logic [ADDR_W-1:0] random_base();
		return ADDR_W'($urandom());
	endfunction

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_pixel(string name, pixel_t got, pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %06h expected %06h", $time, name, got, exp);
		end
	endtask

	task automatic check_dvi(string name, dvi_word_t got, dvi_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			dvi_errors++;
			$display("[FAIL] %0t %s got %06h expected %06h", $time, name, got, exp);
		end
	endtask

	task automatic check_sync(string name, vsync_t got, vsync_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %03b expected %03b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_test(string name, int failures);
		tests_run++;
		if (failures == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, failures);
		end
	endtask

	////////////////////
	// Compare process
	////////////////////

	// Position rebuilt from the output syncs alone
	always @(posedge clk_25mhz) begin : compare
		pixel_t exp_p;
		if (!dvi_rst_n) begin
			// Base taken when the display is enabled
			cmp_x = 0;
			cmp_y = 0;
			frame_base <= mem_start;
		end else if (!sync.vsync) begin
			cmp_x = 0;
			cmp_y = 0;
		end
		if (!sync.blank) begin
			exp_p = expected_pixel(frame_base, cmp_x, cmp_y);
			if (compare_en) begin
				check_pixel("pixel", pixel, exp_p);
				check_dvi("dvi", dvi, dvi_pack(exp_p));
			end
			cmp_x = cmp_x + 1;
			if (cmp_x == 640) begin
				cmp_x = 0;
				cmp_y = cmp_y + 1;
				// After the last pixel the next frame uses the newest base
				if (cmp_y == 480) begin
					frame_base  <= mem_start;
					frames_done <= frames_done + 1;
				end
			end
		end else if (compare_en) begin
			check_pixel("pixel", pixel, '0);
			check_dvi("dvi", dvi, '0);
		end
	end

	////////////////////
	// Waits
	////////////////////

	// 0 hsync, 1 vsync, 2 inverted dvi_rst_n
	function automatic logic pick(int sel);
		case (sel)
			0: return sync.hsync;
			1: return sync.vsync;
			default: return !dvi_rst_n;
		endcase
	endfunction

	task automatic wait_falls(int sel, int count, int limit, string what);
		logic prev;
		int   seen;
		int   n;
		seen = 0;
		n = 0;
		@(posedge clk_25mhz);
		prev = pick(sel);
		while (seen < count && n < limit) begin
			@(posedge clk_25mhz);
			n++;
			if (prev && !pick(sel))
				seen++;
			prev = pick(sel);
		end
		if (seen < count) begin
			$display("Timeout after %0d cycles waiting for %s", n, what);
			errors++;
			hung = 1'b1;
		end
	endtask

	task automatic wait_frames(int count, int limit);
		int target;
		int n;
		target = frames_done + count;
		n = 0;
		while (frames_done < target && n < limit) begin
			@(posedge clk_25mhz);
			n++;
		end
		if (frames_done < target) begin
			$display("Timeout after %0d cycles waiting for a checked frame", n);
			errors++;
			hung = 1'b1;
		end
	endtask

	// New base, enable, then wait out the priming
	task automatic start_display();
		@(negedge clk_25mhz);
		mem_start  = random_base();
		display_on = 1'b1;
		wait_falls(2, 1, 4000, "dvi_rst_n to rise");
	endtask

	task automatic check_idle();
		check_sync("sync", sync, vsync_t'(3'b111));
		check_bit("wb_req.cyc", wb_req.cyc, 1'b0);
		check_bit("wb_req.stb", wb_req.stb, 1'b0);
		check_bit("dvi_rst_n", dvi_rst_n, 1'b0);
		check_bit("underrun", underrun, 1'b0);
		check_pixel("pixel", pixel, '0);
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_idle();
		int e0;
		e0 = errors;
		repeat (3) @(posedge clk_25mhz);
		check_idle();
		report_test("idle after reset", errors - e0);
	endtask

	// One frame from vsync fall to vsync fall
	task automatic test_timing();
		int   e0;
		int   cycles;
		int   vs_low;
		int   hs_low;
		int   act;
		int   act_lines;
		int   lines;
		int   bad_lines;
		int   line_len;
		logic hs_prev;
		logic vs_prev;
		logic bl_prev;
		logic done;
		e0 = errors;
		cycles = 0;
		vs_low = 0;
		hs_low = 0;
		act = 0;
		act_lines = 0;
		lines = 0;
		bad_lines = 0;
		line_len = -1;
		done = 1'b0;
		wait_falls(1, 1, 900000, "vsync to fall");
		while (!done && cycles < 900000) begin
			cycles++;
			if (!sync.vsync)
				vs_low++;
			if (!sync.hsync)
				hs_low++;
			if (!sync.blank)
				act++;
			if (line_len >= 0)
				line_len++;
			hs_prev = sync.hsync;
			vs_prev = sync.vsync;
			bl_prev = sync.blank;
			@(posedge clk_25mhz);
			if (hs_prev && !sync.hsync) begin
				lines++;
				if (line_len >= 0 && line_len != 800)
					bad_lines++;
				line_len = 0;
			end
			if (bl_prev && !sync.blank)
				act_lines++;
			done = vs_prev && !sync.vsync;
		end
		if (!done) begin
			$display("Timeout: frame never ended while measuring timing");
			errors++;
			hung = 1'b1;
		end
		check_count("frame cycles", cycles, 420000);
		check_count("vsync low cycles", vs_low, 1600);
		check_count("hsync low cycles", hs_low, 525 * 96);
		check_count("lines", lines, 525);
		check_count("lines not 800 long", bad_lines, 0);
		check_count("active lines", act_lines, 480);
		check_count("active cycles", act, 480 * 640);
		report_test("video timing", errors - e0);
	endtask

	// Base changes mid frame and the old one holds to the frame end
	task automatic test_frames();
		int e0;
		int d0;
		e0 = errors;
		d0 = dvi_errors;
		repeat (2) begin
			wait_falls(1, 1, 900000, "vsync to fall");
			wait_falls(0, 100 + int'($urandom_range(200)), 300000, "hsync to fall");
			@(negedge clk_25mhz);
			mem_start = random_base();
			wait_frames(1, 900000);
		end
		report_test("frame data", (errors - e0) - (dvi_errors - d0));
		report_test("dvi packing", dvi_errors - d0);
	endtask

	task automatic test_display_cycle();
		int e0;
		e0 = errors;
		wait_falls(1, 1, 900000, "vsync to fall");
		wait_falls(0, 150, 300000, "hsync to fall");
		@(negedge clk_25mhz);
		display_on = 1'b0;
		// Control state settles one edge after the datapath
		repeat (2) @(posedge clk_25mhz);
		check_idle();
		repeat (20) @(negedge clk_25mhz);
		start_display();
		wait_frames(1, 900000);
		report_test("display off and on", errors - e0);
	endtask

	task automatic test_underrun();
		int e0;
		e0 = errors;
		wait_falls(1, 1, 900000, "vsync to fall");
		wait_falls(0, 100, 300000, "hsync to fall");
		@(negedge clk_25mhz);
		compare_en = 1'b0;
		ack_hold   = 1'b1;
		repeat (2000) @(posedge clk_25mhz);
		check_bit("underrun", underrun, 1'b1);
		@(negedge clk_25mhz);
		ack_hold = 1'b0;
		// Sticky across the frame boundary
		wait_falls(1, 1, 900000, "vsync to fall");
		check_bit("underrun", underrun, 1'b1);
		@(negedge clk_25mhz);
		display_on = 1'b0;
		repeat (2) @(posedge clk_25mhz);
		check_bit("underrun", underrun, 1'b0);
		@(negedge clk_25mhz);
		compare_en = 1'b1;
		start_display();
		wait_frames(1, 900000);
		check_bit("underrun", underrun, 1'b0);
		report_test("underrun", errors - e0);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin : main
		void'($urandom(32'h7747dbec));
		clk_25mhz    = 1'b0;
		rst_n        = 1'b0;
		display_on   = 1'b0;
		mem_start    = '0;
		ack_hold     = 1'b0;
		compare_en   = 1'b0;
		frames_done  = 0;
		cmp_x        = 0;
		cmp_y        = 0;
		checks       = 0;
		errors       = 0;
		dvi_errors   = 0;
		tests_run    = 0;
		tests_failed = 0;
		hung         = 1'b0;
		repeat (5) @(negedge clk_25mhz);
		rst_n      = 1'b1;
		compare_en = 1'b1;

		test_idle();
		start_display();
		if (!hung)
			test_timing();
		if (!hung)
			test_frames();
		if (!hung)
			test_display_cycle();
		if (!hung)
			test_underrun();

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
